// ==== rtl/ip_pkg.sv ====
package ip_pkg;

    // Ethernet framing followed by a fixed 20-byte IPv4 header
    typedef struct packed {
        logic [47:0] eth_dest_mac;
        logic [47:0] eth_src_mac;
        logic [15:0] eth_type;
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    // IANA protocol numbers
    typedef enum logic [7:0] {
        PROTO_ICMP = 8'd1,
        PROTO_TCP  = 8'd6,
        PROTO_UDP  = 8'd17
    } ip_proto_e;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_HDR     = 2'd1,
        ST_PAYLOAD = 2'd2,
        ST_DROP    = 2'd3
    } demux_state_e;

endpackage

// ==== rtl/ip_intf.sv ====
`timescale 1ns/1ns

interface ip_intf #(
    parameter DATA_WIDTH = 8,
    parameter KEEP_WIDTH = DATA_WIDTH / 8,
    parameter USER_WIDTH = 1
) (
    input logic clk
);
    import ip_pkg::*;

    // Header channel
    logic                  hdr_valid;
    logic                  hdr_ready;
    ip_hdr_t               hdr;

    // Payload stream
    logic [DATA_WIDTH-1:0] payload_tdata;
    logic [KEEP_WIDTH-1:0] payload_tkeep;
    logic                  payload_tvalid;
    logic                  payload_tready;
    logic                  payload_tlast;
    logic [USER_WIDTH-1:0] payload_tuser;

    modport SLAVE (
        input  clk,
        input  hdr_valid, hdr,
        output hdr_ready,
        input  payload_tdata, payload_tkeep, payload_tvalid, payload_tlast, payload_tuser,
        output payload_tready
    );

    modport MASTER (
        input  clk,
        output hdr_valid, hdr,
        input  hdr_ready,
        output payload_tdata, payload_tkeep, payload_tvalid, payload_tlast, payload_tuser,
        input  payload_tready
    );

endinterface

// ==== rtl/ip_hdr_check.sv ====
`timescale 1ns/1ns

module ip_hdr_check #(
    parameter  M_COUNT   = 4,
    localparam SEL_WIDTH = $clog2(M_COUNT)
) (
    input  ip_pkg::ip_hdr_t        hdr,
    output logic [SEL_WIDTH-1:0]   select,
    output logic                   drop
);
    import ip_pkg::*;

    logic [159:0] ip_words;
    logic [19:0]  sum;
    logic [16:0]  fold1;
    logic [15:0]  fold2;
    logic         csum_ok;
    logic         fmt_ok;

    // The ten 16-bit words of the IPv4 header, checksum included
    assign ip_words = {
        hdr.version, hdr.ihl, hdr.dscp, hdr.ecn,
        hdr.length,
        hdr.identification,
        hdr.flags, hdr.fragment_offset,
        hdr.ttl, hdr.protocol,
        hdr.header_checksum,
        hdr.source_ip,
        hdr.dest_ip
    };

    always_comb begin
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 20'(ip_words[i*16 +: 16]);
        end
    end

    // Two end-around carry folds are enough for ten words
    assign fold1 = 17'(sum[15:0]) + 17'(sum[19:16]);
    assign fold2 = fold1[15:0] + 16'(fold1[16]);

    assign csum_ok = (fold2 == 16'hffff);

    assign fmt_ok = (hdr.version == 4'd4) &&
                    (hdr.ihl == 4'd5) &&
                    (hdr.ttl != 8'd0);

    assign drop = !(csum_ok && fmt_ok);

    // Protocol to output port
    always_comb begin
        case (hdr.protocol)
            PROTO_ICMP: select = SEL_WIDTH'(0);
            PROTO_TCP:  select = SEL_WIDTH'(1);
            PROTO_UDP:  select = SEL_WIDTH'(2);
            default:    select = SEL_WIDTH'(M_COUNT - 1);
        endcase
    end

endmodule

// ==== rtl/ip_demux.sv ====
`timescale 1ns/1ns

module ip_demux #(
    parameter  M_COUNT    = 4,
    parameter  DATA_WIDTH = 8,
    parameter  KEEP_WIDTH = DATA_WIDTH / 8,
    parameter  USER_WIDTH = 1,
    localparam SEL_WIDTH  = $clog2(M_COUNT)
) (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           enable,
    input  logic                           drop,
    input  logic [SEL_WIDTH-1:0]           select,

    input  logic                           s_hdr_valid,
    output logic                           s_hdr_ready,
    input  ip_pkg::ip_hdr_t                s_hdr,
    input  logic [DATA_WIDTH-1:0]          s_tdata,
    input  logic [KEEP_WIDTH-1:0]          s_tkeep,
    input  logic                           s_tvalid,
    output logic                           s_tready,
    input  logic                           s_tlast,
    input  logic [USER_WIDTH-1:0]          s_tuser,

    output logic [M_COUNT-1:0]             m_hdr_valid,
    input  logic [M_COUNT-1:0]             m_hdr_ready,
    output ip_pkg::ip_hdr_t                m_hdr,
    output logic [M_COUNT*DATA_WIDTH-1:0]  m_tdata,
    output logic [M_COUNT*KEEP_WIDTH-1:0]  m_tkeep,
    output logic [M_COUNT-1:0]             m_tvalid,
    input  logic [M_COUNT-1:0]             m_tready,
    output logic [M_COUNT-1:0]             m_tlast,
    output logic [M_COUNT*USER_WIDTH-1:0]  m_tuser
);
    import ip_pkg::*;

    demux_state_e          state;
    demux_state_e          state_next;
    logic [SEL_WIDTH-1:0]  sel_q;
    logic [M_COUNT-1:0]    sel_onehot;
    ip_hdr_t               hdr_q;
    logic                  idle_q;
    logic                  payload_done;
    logic                  pay_active;
    logic                  hdr_accept;
    logic                  hdr_sent;
    logic                  last_xfer;

    assign s_hdr_ready = idle_q && enable;
    assign hdr_accept  = s_hdr_valid && s_hdr_ready;

    assign sel_onehot  = {{(M_COUNT-1){1'b0}}, 1'b1} << sel_q;
    assign hdr_sent    = (state == ST_HDR) && m_hdr_ready[sel_q];

    // Payload may run ahead of the header while it waits at the port
    assign pay_active  = ((state == ST_HDR) && !payload_done) || (state == ST_PAYLOAD);

    assign last_xfer   = s_tvalid && s_tready && s_tlast;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (hdr_accept) begin
                    state_next = drop ? ST_DROP : ST_HDR;
                end
            end
            ST_HDR: begin
                if (hdr_sent) begin
                    state_next = (payload_done || last_xfer) ? ST_IDLE : ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                if (last_xfer) begin
                    state_next = ST_IDLE;
                end
            end
            ST_DROP: begin
                if (last_xfer) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            sel_q        <= '0;
            idle_q       <= 1'b0;
            payload_done <= 1'b0;
        end else begin
            state  <= state_next;
            idle_q <= (state_next == ST_IDLE);
            if (hdr_accept) begin
                sel_q <= select;
            end
            if (state_next != ST_HDR) begin
                payload_done <= 1'b0;
            end else if (last_xfer) begin
                payload_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            hdr_q <= s_hdr;
        end
    end

    assign m_hdr       = hdr_q;
    assign m_hdr_valid = (state == ST_HDR) ? sel_onehot : '0;

    // Data fans out to every port, only the selected tvalid qualifies it
    assign m_tdata  = {M_COUNT{s_tdata}};
    assign m_tkeep  = {M_COUNT{s_tkeep}};
    assign m_tlast  = {M_COUNT{s_tlast}};
    assign m_tuser  = {M_COUNT{s_tuser}};
    assign m_tvalid = (pay_active && s_tvalid) ? sel_onehot : '0;

    always_comb begin
        if (state == ST_DROP) begin
            s_tready = 1'b1;
        end else if (pay_active) begin
            s_tready = m_tready[sel_q];
        end else begin
            s_tready = 1'b0;
        end
    end

    a_hdr_valid_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(m_hdr_valid)
    );

    // Payload only reaches the port latched with the accepted header
    a_tvalid_latched_port: assert property (
        @(posedge clk) disable iff (!rst_n)
        (m_tvalid != '0) |-> (state inside {ST_HDR, ST_PAYLOAD}) && (m_tvalid == sel_onehot)
    );

    a_hdr_ready_idle_only: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state != ST_IDLE) |-> !s_hdr_ready
    );

endmodule

// ==== rtl/ip_demux_wrapper.sv ====
`timescale 1ns/1ns

module ip_demux_wrapper #(
    parameter  M_COUNT    = 4,
    parameter  DATA_WIDTH = 8,
    parameter  KEEP_WIDTH = DATA_WIDTH / 8,
    parameter  USER_WIDTH = 1,
    localparam SEL_WIDTH  = $clog2(M_COUNT)
) (
    input  logic                  clk,
    input  logic                  rst_n,

    ip_intf.SLAVE                 s_ip,
    ip_intf.MASTER                m_ip [M_COUNT],

    input  logic                  enable,
    input  logic                  drop,
    input  logic [SEL_WIDTH-1:0]  select
);

    logic [M_COUNT-1:0]            m_hdr_valid;
    logic [M_COUNT-1:0]            m_hdr_ready;
    ip_pkg::ip_hdr_t               m_hdr;
    logic [M_COUNT*DATA_WIDTH-1:0] m_tdata;
    logic [M_COUNT*KEEP_WIDTH-1:0] m_tkeep;
    logic [M_COUNT-1:0]            m_tvalid;
    logic [M_COUNT-1:0]            m_tready;
    logic [M_COUNT-1:0]            m_tlast;
    logic [M_COUNT*USER_WIDTH-1:0] m_tuser;

    generate
        for (genvar i = 0; i < M_COUNT; i++) begin : g_port
            assign m_ip[i].hdr_valid      = m_hdr_valid[i];
            assign m_hdr_ready[i]         = m_ip[i].hdr_ready;
            assign m_ip[i].hdr            = m_hdr;
            assign m_ip[i].payload_tdata  = m_tdata[i*DATA_WIDTH +: DATA_WIDTH];
            assign m_ip[i].payload_tkeep  = m_tkeep[i*KEEP_WIDTH +: KEEP_WIDTH];
            assign m_ip[i].payload_tvalid = m_tvalid[i];
            assign m_tready[i]            = m_ip[i].payload_tready;
            assign m_ip[i].payload_tlast  = m_tlast[i];
            assign m_ip[i].payload_tuser  = m_tuser[i*USER_WIDTH +: USER_WIDTH];
        end
    endgenerate

    ip_demux #(
        .M_COUNT    (M_COUNT),
        .DATA_WIDTH (DATA_WIDTH),
        .KEEP_WIDTH (KEEP_WIDTH),
        .USER_WIDTH (USER_WIDTH)
    ) u_ip_demux (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .drop        (drop),
        .select      (select),
        .s_hdr_valid (s_ip.hdr_valid),
        .s_hdr_ready (s_ip.hdr_ready),
        .s_hdr       (s_ip.hdr),
        .s_tdata     (s_ip.payload_tdata),
        .s_tkeep     (s_ip.payload_tkeep),
        .s_tvalid    (s_ip.payload_tvalid),
        .s_tready    (s_ip.payload_tready),
        .s_tlast     (s_ip.payload_tlast),
        .s_tuser     (s_ip.payload_tuser),
        .m_hdr_valid (m_hdr_valid),
        .m_hdr_ready (m_hdr_ready),
        .m_hdr       (m_hdr),
        .m_tdata     (m_tdata),
        .m_tkeep     (m_tkeep),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .m_tlast     (m_tlast),
        .m_tuser     (m_tuser)
    );

endmodule

// ==== rtl/ip_rx_demux_top.sv ====
`timescale 1ns/1ns

module ip_rx_demux_top #(
    parameter  M_COUNT    = 4,
    parameter  DATA_WIDTH = 8,
    parameter  KEEP_WIDTH = DATA_WIDTH / 8,
    parameter  USER_WIDTH = 1,
    localparam SEL_WIDTH  = $clog2(M_COUNT)
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,

    ip_intf.SLAVE   s_ip,
    ip_intf.MASTER  m_ip [M_COUNT]
);

    logic [SEL_WIDTH-1:0] select;
    logic                 drop;

    // ICMP, TCP and UDP take ports 0 to 2, the last port catches the rest
    if (M_COUNT < 4) begin : g_count_check
        $error("ip_rx_demux_top needs M_COUNT of at least 4, got %0d", M_COUNT);
    end

    ip_hdr_check #(
        .M_COUNT (M_COUNT)
    ) u_hdr_check (
        .hdr    (s_ip.hdr),
        .select (select),
        .drop   (drop)
    );

    ip_demux_wrapper #(
        .M_COUNT    (M_COUNT),
        .DATA_WIDTH (DATA_WIDTH),
        .KEEP_WIDTH (KEEP_WIDTH),
        .USER_WIDTH (USER_WIDTH)
    ) u_demux (
        .clk    (clk),
        .rst_n  (rst_n),
        .s_ip   (s_ip),
        .m_ip   (m_ip),
        .enable (enable),
        .drop   (drop),
        .select (select)
    );

endmodule

// ==== tb/tb_ip_rx_demux.sv ====
`timescale 1ns/1ns

module tb_ip_rx_demux;
    import ip_pkg::*;

    localparam int N_PORTS     = 4;
    localparam int CLK_PERIOD  = 100;
    localparam int NUM_FRAMES  = 17;
    localparam int BAD_NONE    = 0;
    localparam int BAD_CSUM    = 1;
    localparam int BAD_TTL     = 2;
    localparam int BAD_VERSION = 3;
    localparam int BAD_IHL     = 4;

    typedef struct packed {
        logic [7:0] tdata;
        logic       tkeep;
        logic       tlast;
        logic       tuser;
    } beat_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                enable;
    logic                stall_mode;
    logic [N_PORTS-1:0]  sink_hdr_ready;
    logic [N_PORTS-1:0]  sink_tready;
    logic [N_PORTS-1:0]  hv;
    logic [N_PORTS-1:0]  tv;
    ip_hdr_t             out_hdr [N_PORTS];
    beat_t               out_beat [N_PORTS];
    logic                hdr_taken;
    logic                beat_taken;
    logic [15:0]         lfsr_state = 16'd50;
    int                  cycle_count = 0;
    logic                rst_q = 1'b0;
    string               test_name = "reset";

    // Frame currently entering the DUT and the port it is bound for
    logic                in_active = 1'b0;
    logic                in_keep = 1'b0;
    int                  in_port = 0;
    ip_hdr_t             exp_hdr [N_PORTS][$];
    beat_t               exp_beat [N_PORTS][$];

    ip_intf #(.DATA_WIDTH(8)) s_ip (.clk(clk));
    ip_intf #(.DATA_WIDTH(8)) m_ip [N_PORTS] (.clk(clk));

    ip_rx_demux_top #(
        .M_COUNT    (N_PORTS),
        .DATA_WIDTH (8),
        .KEEP_WIDTH (1),
        .USER_WIDTH (1)
    ) u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .s_ip   (s_ip),
        .m_ip   (m_ip)
    );

    for (genvar i = 0; i < N_PORTS; i++) begin : g_sink
        assign m_ip[i].hdr_ready      = sink_hdr_ready[i];
        assign m_ip[i].payload_tready = sink_tready[i];
        assign hv[i]                  = m_ip[i].hdr_valid;
        assign tv[i]                  = m_ip[i].payload_tvalid;
        assign out_hdr[i]             = m_ip[i].hdr;
        assign out_beat[i]            = {m_ip[i].payload_tdata, m_ip[i].payload_tkeep,
                                         m_ip[i].payload_tlast, m_ip[i].payload_tuser};
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [271:0] expected,
                                   input logic [271:0] actual);
        $display("FAIL %s: expected %h, actual %h", what, expected, actual);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("Problem in %s: %s", test_name, what);
        abort_run();
    endtask

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    // Ones' complement sum over the 20 header bytes with end-around carry
    function automatic logic [15:0] ones_sum(input ip_hdr_t h);
        logic [159:0] w;
        logic [16:0]  acc;
        w = h[159:0];
        acc = '0;
        for (int k = 0; k < 10; k++) begin
            acc = {1'b0, acc[15:0]} + {1'b0, w[k*16 +: 16]};
            acc = {1'b0, acc[15:0]} + {16'd0, acc[16]};
        end
        return acc[15:0];
    endfunction

    function automatic logic header_ok(input ip_hdr_t h);
        return (ones_sum(h) == 16'hffff) && (h.version == 4'd4) && (h.ihl == 4'd5) &&
               (h.ttl != 8'd0);
    endfunction

    function automatic int port_of(input logic [7:0] proto);
        case (proto)
            PROTO_ICMP: return 0;
            PROTO_TCP:  return 1;
            PROTO_UDP:  return 2;
            default:    return N_PORTS - 1;
        endcase
    endfunction

    function automatic ip_hdr_t make_hdr(input logic [7:0] proto, input int len, input int fault);
        ip_hdr_t h;
        h = '0;
        h.eth_dest_mac   = 48'h02_00_00_00_00_01;
        h.eth_src_mac    = 48'h02_00_00_00_00_02;
        h.eth_type       = 16'h0800;
        h.version        = (fault == BAD_VERSION) ? 4'd6 : 4'd4;
        h.ihl            = (fault == BAD_IHL) ? 4'd6 : 4'd5;
        h.length         = 16'(20 + len);
        h.identification = 16'(rand_bits(16));
        h.ttl            = (fault == BAD_TTL) ? 8'd0 : 8'd64;
        h.protocol       = proto;
        h.source_ip      = {8'd10, 8'd0, 8'd0, 8'(rand_bits(8))};
        h.dest_ip        = 32'hc0a8_0001;
        h.header_checksum = ~ones_sum(h);
        if (fault == BAD_CSUM)
            h.header_checksum = h.header_checksum ^ 16'h0040;
        return h;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int i = 0; i < N_PORTS; i++) begin
            n = n + exp_hdr[i].size() + exp_beat[i].size();
        end
        return n;
    endfunction

    // Note the handshakes of this edge, then drive 5 ns later
    task automatic tick();
        @(posedge clk);
        hdr_taken  = s_ip.hdr_valid && s_ip.hdr_ready;
        beat_taken = s_ip.payload_tvalid && s_ip.payload_tready;
        #5;
        sink_hdr_ready = stall_mode ? N_PORTS'(rand_bits(N_PORTS)) : '1;
        sink_tready    = stall_mode ? N_PORTS'(rand_bits(N_PORTS)) : '1;
    endtask

    task automatic send_frame(input string name, input ip_hdr_t hdr, input int len,
                              input logic enable_off);
        test_name = name;
        s_ip.hdr = hdr;
        s_ip.hdr_valid = 1'b1;
        do tick(); while (!hdr_taken);
        s_ip.hdr_valid = 1'b0;
        if (enable_off)
            enable = 1'b0;
        for (int k = 0; k < len; k++) begin
            s_ip.payload_tdata  = 8'(rand_bits(8));
            s_ip.payload_tkeep  = 1'b1;
            s_ip.payload_tlast  = (k == len - 1);
            s_ip.payload_tuser  = 1'(rand_bits(1));
            s_ip.payload_tvalid = 1'b1;
            do tick(); while (!beat_taken);
        end
        s_ip.payload_tvalid = 1'b0;
    endtask

    task automatic drain();
        while (pending() != 0) begin
            tick();
        end
    endtask

    // Input side goes first so a beat passing straight through is queued in time
    always @(posedge clk) begin
        ip_hdr_t eh;
        beat_t   eb;
        if (rst_n) begin
            if (s_ip.hdr_valid && s_ip.hdr_ready) begin
                in_keep   = header_ok(s_ip.hdr);
                in_port   = port_of(s_ip.hdr.protocol);
                in_active = 1'b1;
                if (in_keep)
                    exp_hdr[in_port].push_back(s_ip.hdr);
            end
            if (s_ip.payload_tvalid && s_ip.payload_tready) begin
                if (in_keep)
                    exp_beat[in_port].push_back({s_ip.payload_tdata, s_ip.payload_tkeep,
                                                 s_ip.payload_tlast, s_ip.payload_tuser});
                if (s_ip.payload_tlast)
                    in_active = 1'b0;
            end
            for (int i = 0; i < N_PORTS; i++) begin
                if (hv[i] && sink_hdr_ready[i]) begin
                    assert (exp_hdr[i].size() > 0)
                        else report_problem($sformatf("unexpected header on port %0d", i));
                    eh = exp_hdr[i].pop_front();
                    assert (out_hdr[i] == eh)
                        else report_mismatch($sformatf("%s header port %0d", test_name, i),
                                             eh, out_hdr[i]);
                end
                if (tv[i] && sink_tready[i]) begin
                    assert (exp_beat[i].size() > 0)
                        else report_problem($sformatf("unexpected payload beat on port %0d", i));
                    eb = exp_beat[i].pop_front();
                    assert (out_beat[i] == eb)
                        else report_mismatch($sformatf("%s beat port %0d", test_name, i),
                                             eb, out_beat[i]);
                end
            end
        end
    end

    always @(posedge clk) begin
        rst_q <= rst_n;
        cycle_count <= cycle_count + 1;
    end

    a_one_hdr_valid: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hv))
        else report_problem("more than one port shows hdr_valid");

    a_tvalid_routed: assert property (@(posedge clk) disable iff (!rst_n)
        (tv != '0) |-> (in_active && in_keep && (tv == (N_PORTS'(1) << in_port))))
        else report_problem("payload_tvalid on a port with no frame routed to it");

    a_stall_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        ((tv & ~sink_tready) != '0) |-> !s_ip.payload_tready)
        else report_problem("input accepted a beat while the selected sink stalled");

    a_enable_blocks: assert property (@(posedge clk) disable iff (!rst_n)
        !enable |-> !s_ip.hdr_ready)
        else report_problem("hdr_ready high while enable is low");

    a_reset_quiet: assert property (@(posedge clk)
        (cycle_count > 0 && (!rst_n || !rst_q)) |-> (hv == '0 && tv == '0))
        else report_problem("output valid during or right after reset");

    initial begin
        #((NUM_FRAMES * 200 + 8) * CLK_PERIOD);
        report_problem("watchdog expired, the run hung");
    end

    initial begin
        int proto_pick;
        int len_pick;
        logic [7:0] protos [4];
        protos = '{8'd1, 8'd6, 8'd17, 8'd99};
        rst_n = 1'b0;
        enable = 1'b1;
        stall_mode = 1'b0;
        sink_hdr_ready = '1;
        sink_tready = '1;
        s_ip.hdr_valid = 1'b0;
        s_ip.hdr = '0;
        s_ip.payload_tdata = '0;
        s_ip.payload_tkeep = '0;
        s_ip.payload_tvalid = 1'b0;
        s_ip.payload_tlast = 1'b0;
        s_ip.payload_tuser = '0;
        repeat (8) tick();
        rst_n = 1'b1;
        tick();

        for (int k = 0; k < 4; k++) begin
            send_frame("routing", make_hdr(protos[k], k + 2, BAD_NONE), k + 2, 1'b0);
        end
        drain();

        send_frame("drop checksum", make_hdr(PROTO_TCP, 3, BAD_CSUM), 3, 1'b0);
        send_frame("drop ttl", make_hdr(PROTO_UDP, 2, BAD_TTL), 2, 1'b0);
        send_frame("drop version", make_hdr(PROTO_ICMP, 4, BAD_VERSION), 4, 1'b0);
        send_frame("drop ihl", make_hdr(8'd99, 1, BAD_IHL), 1, 1'b0);
        send_frame("after drop", make_hdr(PROTO_UDP, 5, BAD_NONE), 5, 1'b0);
        drain();

        // Random sink stalls on both channels
        stall_mode = 1'b1;
        for (int k = 0; k < 6; k++) begin
            proto_pick = rand_bits(2);
            len_pick = 1 + rand_bits(3);
            send_frame("backpressure", make_hdr(protos[proto_pick], len_pick, BAD_NONE),
                       len_pick, 1'b0);
        end
        drain();

        // Enable falls right after a header is taken
        send_frame("enable", make_hdr(PROTO_TCP, 4, BAD_NONE), 4, 1'b1);
        drain();
        s_ip.hdr = make_hdr(PROTO_ICMP, 3, BAD_NONE);
        s_ip.hdr_valid = 1'b1;
        repeat (20) tick();
        enable = 1'b1;
        send_frame("enable resume", s_ip.hdr, 3, 1'b0);
        drain();
        stall_mode = 1'b0;
        repeat (4) tick();

        if (!in_active && pending() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            report_problem("frames still outstanding at the end of the run");
        end
    end

endmodule

// ==== ip_rx_demux_top.f ====
rtl/ip_pkg.sv
rtl/ip_intf.sv
rtl/ip_hdr_check.sv
rtl/ip_demux.sv
rtl/ip_demux_wrapper.sv
rtl/ip_rx_demux_top.sv
tb/tb_ip_rx_demux.sv
